// ==== source/dispatch_settings.svh ====
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// instruction word and immediate width
`define DISP_XLEN    32

// scalar register file
`define DISP_NREGS   32
`define DISP_REG_W   5

// one fu_busy bit per functional unit
`define DISP_NUM_FU  3

// producer tag width in the status table
`define DISP_TAG_W   2

`endif

// ==== source/dispatch_pkg.sv ====
`include "dispatch_settings.svh"

package dispatch_pkg;

    // major opcodes, low seven bits of the word
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OPIMM  = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // fu_busy bit is (unit - 1)
    typedef enum logic [1:0] {
        FU_NONE   = 2'd0,
        FU_ALU    = 2'd1,
        FU_LDST   = 2'd2,
        FU_BRANCH = 2'd3
    } fu_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_XOR,
        OP_SRL,
        OP_OR,
        OP_AND,
        OP_LOAD,
        OP_STORE,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JAL
    } op_t;

    // which unit will produce a pending register
    typedef enum logic [`DISP_TAG_W-1:0] {
        TAG_NONE = 2'd0,
        TAG_ALU  = 2'd1,
        TAG_JUMP = 2'd2,
        TAG_LOAD = 2'd3
    } tag_t;

endpackage

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps
`include "dispatch_settings.svh"

module instr_decoder import dispatch_pkg::*; (
    input  logic [`DISP_XLEN-1:0]  instr,
    output fu_t                    fu,
    output op_t                    op,
    output logic [`DISP_REG_W-1:0] rd,
    output logic [`DISP_REG_W-1:0] rs1,
    output logic [`DISP_REG_W-1:0] rs2,
    output logic [`DISP_XLEN-1:0]  imm,
    output logic                   use_imm,
    output logic                   reg_write,
    output tag_t                   rd_tag
);

    opcode_t                opcode;
    logic [2:0]             funct3;
    logic                   writes_rd;
    logic [`DISP_XLEN-1:0]  imm_i;
    logic [`DISP_XLEN-1:0]  imm_s;
    logic [`DISP_XLEN-1:0]  imm_b;
    logic [`DISP_XLEN-1:0]  imm_j;

    // shared by register and immediate ALU forms
    function automatic op_t alu_op(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  alu_op = sub ? OP_SUB : OP_ADD;
            3'b001:  alu_op = OP_SLL;
            3'b010:  alu_op = OP_SLT;
            3'b100:  alu_op = OP_XOR;
            3'b101:  alu_op = OP_SRL;
            3'b110:  alu_op = OP_OR;
            default: alu_op = OP_AND;
        endcase
    endfunction

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    // immediates per format, sign extended from bit 31
    assign imm_i = {{(`DISP_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`DISP_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`DISP_XLEN-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(`DISP_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};

    always_comb begin
        fu        = FU_NONE;
        op        = OP_ADD;
        rd        = '0;
        rs1       = '0;
        rs2       = '0;
        imm       = '0;
        use_imm   = 1'b0;
        writes_rd = 1'b0;
        rd_tag    = TAG_NONE;
        case (opcode)
            OPC_OP: begin
                // funct3 011 has no operation here
                if (funct3 != 3'b011) begin
                    fu        = FU_ALU;
                    op        = alu_op(funct3, instr[30]);
                    rd        = instr[11:7];
                    rs1       = instr[19:15];
                    rs2       = instr[24:20];
                    writes_rd = 1'b1;
                    rd_tag    = TAG_ALU;
                end
            end
            OPC_OPIMM: begin
                if (funct3 != 3'b011) begin
                    fu        = FU_ALU;
                    op        = alu_op(funct3, 1'b0);
                    rd        = instr[11:7];
                    rs1       = instr[19:15];
                    imm       = imm_i;
                    use_imm   = 1'b1;
                    writes_rd = 1'b1;
                    rd_tag    = TAG_ALU;
                end
            end
            OPC_LOAD: begin
                fu        = FU_LDST;
                op        = OP_LOAD;
                rd        = instr[11:7];
                rs1       = instr[19:15];
                imm       = imm_i;
                writes_rd = 1'b1;
                rd_tag    = TAG_LOAD;
            end
            OPC_STORE: begin
                fu  = FU_LDST;
                op  = OP_STORE;
                rs1 = instr[19:15];
                rs2 = instr[24:20];
                imm = imm_s;
            end
            OPC_BRANCH: begin
                if (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) begin
                    fu  = FU_BRANCH;
                    rs1 = instr[19:15];
                    rs2 = instr[24:20];
                    imm = imm_b;
                    case (funct3)
                        3'b001:  op = OP_BNE;
                        3'b100:  op = OP_BLT;
                        3'b101:  op = OP_BGE;
                        default: op = OP_BEQ;
                    endcase
                end
            end
            OPC_JAL: begin
                fu        = FU_BRANCH;
                op        = OP_JAL;
                rd        = instr[11:7];
                imm       = imm_j;
                writes_rd = 1'b1;
                rd_tag    = TAG_JUMP;
            end
            default: begin
            end
        endcase
    end

    // x0 is never a real destination
    assign reg_write = writes_rd && (rd != '0);

endmodule

// ==== source/reg_status_table.sv ====
`timescale 1ns/10ps
`include "dispatch_settings.svh"

module reg_status_table import dispatch_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   set_en,
    input  logic [`DISP_REG_W-1:0] set_reg,
    input  tag_t                   set_tag,
    input  logic                   wb_en,
    input  logic [`DISP_REG_W-1:0] wb_reg,
    input  logic [`DISP_REG_W-1:0] rs1,
    input  logic [`DISP_REG_W-1:0] rs2,
    input  logic [`DISP_REG_W-1:0] rd,
    output tag_t                   t1,
    output tag_t                   t2,
    output logic                   rd_busy
);

    // one pending flag and producer tag per register
    logic [`DISP_NREGS-1:0] busy;
    tag_t                   tags [`DISP_NREGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            tags <= '{default: TAG_NONE};
        end else begin
            if (wb_en) begin
                busy[wb_reg] <= 1'b0;
                tags[wb_reg] <= TAG_NONE;
            end
            // later assignment, so a dispatch beats a writeback to the same reg
            if (set_en && (set_reg != '0)) begin
                busy[set_reg] <= 1'b1;
                tags[set_reg] <= set_tag;
            end
        end
    end

    // writeback bypass on the source reads
    always_comb begin
        t1 = tags[rs1];
        t2 = tags[rs2];
        if (wb_en && (wb_reg == rs1)) begin
            t1 = TAG_NONE;
        end
        if (wb_en && (wb_reg == rs2)) begin
            t2 = TAG_NONE;
        end
    end

    // not bypassed, a cleared rd frees the stall at the next edge
    assign rd_busy = busy[rd];

endmodule

// ==== source/dispatch_stage.sv ====
`timescale 1ns/10ps
`include "dispatch_settings.svh"

module dispatch_stage import dispatch_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    instr_valid,
    input  logic                    branch_miss,
    input  logic [`DISP_NUM_FU-1:0] fu_busy,
    input  fu_t                     fu,
    input  op_t                     op,
    input  logic [`DISP_REG_W-1:0]  rd,
    input  logic [`DISP_REG_W-1:0]  rs1,
    input  logic [`DISP_REG_W-1:0]  rs2,
    input  logic [`DISP_XLEN-1:0]   imm,
    input  logic                    use_imm,
    input  logic                    reg_write,
    input  tag_t                    rd_tag,
    input  tag_t                    t1,
    input  tag_t                    t2,
    input  logic                    rd_busy,
    output logic                    freeze,
    output logic                    set_en,
    output logic [`DISP_REG_W-1:0]  set_reg,
    output tag_t                    set_tag,
    output logic                    issue_valid,
    output fu_t                     issue_fu,
    output op_t                     issue_op,
    output logic [`DISP_REG_W-1:0]  issue_rd,
    output logic [`DISP_REG_W-1:0]  issue_rs1,
    output logic [`DISP_REG_W-1:0]  issue_rs2,
    output logic [`DISP_XLEN-1:0]   issue_imm,
    output logic                    issue_use_imm,
    output tag_t                    issue_t1,
    output tag_t                    issue_t2
);

    logic unit_busy;
    logic waw;
    logic hazard;
    logic do_dispatch;

    // structural hazard, bit (fu - 1) of fu_busy
    always_comb begin
        case (fu)
            FU_ALU:    unit_busy = fu_busy[0];
            FU_LDST:   unit_busy = fu_busy[1];
            FU_BRANCH: unit_busy = fu_busy[2];
            default:   unit_busy = 1'b0;
        endcase
    end

    assign waw    = reg_write && rd_busy;
    assign hazard = unit_busy || waw;

    // fetch holds the word while frozen
    assign freeze      = instr_valid && hazard && !branch_miss;
    assign do_dispatch = instr_valid && (fu != FU_NONE) && !hazard && !branch_miss;

    // mark rd pending only for an instruction that actually leaves
    assign set_en  = do_dispatch && reg_write;
    assign set_reg = rd;
    assign set_tag = rd_tag;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid   <= 1'b0;
            issue_fu      <= FU_NONE;
            issue_op      <= OP_ADD;
            issue_rd      <= '0;
            issue_rs1     <= '0;
            issue_rs2     <= '0;
            issue_imm     <= '0;
            issue_use_imm <= 1'b0;
            issue_t1      <= TAG_NONE;
            issue_t2      <= TAG_NONE;
        end else if (do_dispatch) begin
            issue_valid   <= 1'b1;
            issue_fu      <= fu;
            issue_op      <= op;
            issue_rd      <= rd;
            issue_rs1     <= rs1;
            issue_rs2     <= rs2;
            issue_imm     <= imm;
            issue_use_imm <= use_imm;
            issue_t1      <= t1;
            issue_t2      <= t2;
        end else begin
            // stall, flush or nothing to issue
            issue_valid   <= 1'b0;
            issue_fu      <= FU_NONE;
            issue_op      <= OP_ADD;
            issue_rd      <= '0;
            issue_rs1     <= '0;
            issue_rs2     <= '0;
            issue_imm     <= '0;
            issue_use_imm <= 1'b0;
            issue_t1      <= TAG_NONE;
            issue_t2      <= TAG_NONE;
        end
    end

endmodule

// ==== source/dispatch_top.sv ====
`timescale 1ns/10ps
`include "dispatch_settings.svh"

module dispatch_top import dispatch_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    instr_valid,
    input  logic [`DISP_XLEN-1:0]   instr,
    input  logic [`DISP_NUM_FU-1:0] fu_busy,
    input  logic                    wb_en,
    input  logic [`DISP_REG_W-1:0]  wb_reg,
    input  logic                    branch_miss,
    output logic                    freeze,
    output logic                    issue_valid,
    output fu_t                     issue_fu,
    output op_t                     issue_op,
    output logic [`DISP_REG_W-1:0]  issue_rd,
    output logic [`DISP_REG_W-1:0]  issue_rs1,
    output logic [`DISP_REG_W-1:0]  issue_rs2,
    output logic [`DISP_XLEN-1:0]   issue_imm,
    output logic                    issue_use_imm,
    output tag_t                    issue_t1,
    output tag_t                    issue_t2
);

    // decoded fields
    fu_t                    dec_fu;
    op_t                    dec_op;
    logic [`DISP_REG_W-1:0] dec_rd;
    logic [`DISP_REG_W-1:0] dec_rs1;
    logic [`DISP_REG_W-1:0] dec_rs2;
    logic [`DISP_XLEN-1:0]  dec_imm;
    logic                   dec_use_imm;
    logic                   dec_reg_write;
    tag_t                   dec_rd_tag;

    // status table lookup and update
    tag_t                   t1;
    tag_t                   t2;
    logic                   rd_busy;
    logic                   set_en;
    logic [`DISP_REG_W-1:0] set_reg;
    tag_t                   set_tag;

    instr_decoder u_decoder (
        .instr(instr), .fu(dec_fu), .op(dec_op), .rd(dec_rd), .rs1(dec_rs1),
        .rs2(dec_rs2), .imm(dec_imm), .use_imm(dec_use_imm),
        .reg_write(dec_reg_write), .rd_tag(dec_rd_tag)
    );

    reg_status_table u_status (
        .CLK(CLK), .nRST(nRST), .set_en(set_en), .set_reg(set_reg), .set_tag(set_tag),
        .wb_en(wb_en), .wb_reg(wb_reg), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .t1(t1), .t2(t2), .rd_busy(rd_busy)
    );

    dispatch_stage u_stage (
        .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .branch_miss(branch_miss),
        .fu_busy(fu_busy), .fu(dec_fu), .op(dec_op), .rd(dec_rd), .rs1(dec_rs1),
        .rs2(dec_rs2), .imm(dec_imm), .use_imm(dec_use_imm), .reg_write(dec_reg_write),
        .rd_tag(dec_rd_tag), .t1(t1), .t2(t2), .rd_busy(rd_busy), .freeze(freeze),
        .set_en(set_en), .set_reg(set_reg), .set_tag(set_tag),
        .issue_valid(issue_valid), .issue_fu(issue_fu), .issue_op(issue_op),
        .issue_rd(issue_rd), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .issue_imm(issue_imm), .issue_use_imm(issue_use_imm),
        .issue_t1(issue_t1), .issue_t2(issue_t2)
    );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen (
    output logic CLK,
    output logic nRST
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // reset held for ten rising edges, released on a falling edge
    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

// ==== bench/dispatch_tb.sv ====
`timescale 1ns/10ps
`include "dispatch_settings.svh"

module dispatch_tb import dispatch_pkg::*; ();

    logic                    CLK;
    logic                    nRST;
    logic                    instr_valid;
    logic [`DISP_XLEN-1:0]   instr;
    logic [`DISP_NUM_FU-1:0] fu_busy;
    logic                    wb_en;
    logic [`DISP_REG_W-1:0]  wb_reg;
    logic                    branch_miss;
    logic                    freeze;
    logic                    issue_valid;
    fu_t                     issue_fu;
    op_t                     issue_op;
    logic [`DISP_REG_W-1:0]  issue_rd;
    logic [`DISP_REG_W-1:0]  issue_rs1;
    logic [`DISP_REG_W-1:0]  issue_rs2;
    logic [`DISP_XLEN-1:0]   issue_imm;
    logic                    issue_use_imm;
    tag_t                    issue_t1;
    tag_t                    issue_t2;

    logic [15:0]             lfsr = 16'd17;
    int                      mismatches = 0;
    int                      timeouts = 0;

    // model of the register status table
    logic [`DISP_NREGS-1:0]  m_busy;
    tag_t                    m_tag [`DISP_NREGS];

    // funct3 lookups, slot 011 of the ALU table is never used
    op_t alu_tab [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_ADD, OP_XOR, OP_SRL, OP_OR, OP_AND};
    op_t br_tab [4] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE};

    // expected issue record after the coming edge
    logic                    exp_valid;
    fu_t                     exp_fu;
    op_t                     exp_op;
    logic [`DISP_REG_W-1:0]  exp_rd;
    logic [`DISP_REG_W-1:0]  exp_rs1;
    logic [`DISP_REG_W-1:0]  exp_rs2;
    logic [`DISP_XLEN-1:0]   exp_imm;
    logic                    exp_use_imm;
    tag_t                    exp_t1;
    tag_t                    exp_t2;

    // reference view of the word in front of the edge
    fu_t                     d_fu;
    op_t                     d_op;
    logic [`DISP_REG_W-1:0]  d_rd;
    logic [`DISP_REG_W-1:0]  d_rs1;
    logic [`DISP_REG_W-1:0]  d_rs2;
    logic [`DISP_XLEN-1:0]   d_imm;
    logic                    d_ui;
    logic                    d_wr;
    tag_t                    d_tag;
    logic [`DISP_NUM_FU:0]   busy_ext;
    logic                    hz;
    logic                    disp;

    clock_gen clk_gen (.CLK(CLK), .nRST(nRST));

    dispatch_top uut (.*);

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    function automatic logic [31:0] encode_word(input logic [6:0] hi, input logic [4:0] r2,
                                                input logic [4:0] r1, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [6:0] opc);
        return {hi, r2, r1, f3, rd, opc};
    endfunction

    // legal word of a random class
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        logic [2:0]  k;
        w = rand_bits(32);
        k = 3'(rand_bits(3) % 32'd6);
        case (k)
            3'd0:    w[6:0] = OPC_OP;
            3'd1:    w[6:0] = OPC_OPIMM;
            3'd2:    w[6:0] = OPC_LOAD;
            3'd3:    w[6:0] = OPC_STORE;
            3'd4:    w[6:0] = OPC_BRANCH;
            default: w[6:0] = OPC_JAL;
        endcase
        if (k < 3'd2 && w[14:12] == 3'b011) begin
            w[14:12] = 3'b000;
        end
        // branch funct3 limited to 000 001 100 101
        if (k == 3'd4) begin
            w[13] = 1'b0;
        end
        return w;
    endfunction

    function automatic void ref_decode(input logic [31:0] w, output fu_t f, output op_t o,
                                       output logic [4:0] rd, output logic [4:0] rs1,
                                       output logic [4:0] rs2, output logic [31:0] imm,
                                       output logic ui, output logic wr, output tag_t tag);
        logic [2:0] f3;
        f3 = w[14:12];
        f = FU_NONE;
        o = OP_ADD;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        ui = 1'b0;
        tag = TAG_NONE;
        case (w[6:0])
            OPC_OP, OPC_OPIMM: begin
                if (f3 != 3'b011) begin
                    f = FU_ALU;
                    rd = w[11:7];
                    rs1 = w[19:15];
                    tag = TAG_ALU;
                    if (w[6:0] == OPC_OP) begin
                        o = (f3 == 3'b000 && w[30]) ? OP_SUB : alu_tab[f3];
                        rs2 = w[24:20];
                    end else begin
                        o = alu_tab[f3];
                        imm = 32'($signed(w[31:20]));
                        ui = 1'b1;
                    end
                end
            end
            OPC_LOAD: begin
                f = FU_LDST;
                o = OP_LOAD;
                rd = w[11:7];
                rs1 = w[19:15];
                imm = 32'($signed(w[31:20]));
                tag = TAG_LOAD;
            end
            OPC_STORE: begin
                f = FU_LDST;
                o = OP_STORE;
                rs1 = w[19:15];
                rs2 = w[24:20];
                imm = 32'($signed({w[31:25], w[11:7]}));
            end
            OPC_BRANCH: begin
                if (!f3[1]) begin
                    f = FU_BRANCH;
                    o = br_tab[{f3[2], f3[0]}];
                    rs1 = w[19:15];
                    rs2 = w[24:20];
                    imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                end
            end
            OPC_JAL: begin
                f = FU_BRANCH;
                o = OP_JAL;
                rd = w[11:7];
                imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
                tag = TAG_JUMP;
            end
            default: f = FU_NONE;
        endcase
        wr = (tag != TAG_NONE) && (rd != 5'd0);
    endfunction

    function automatic void clear_expected();
        exp_valid = 1'b0;
        exp_fu = FU_NONE;
        exp_op = OP_ADD;
        exp_rd = '0;
        exp_rs1 = '0;
        exp_rs2 = '0;
        exp_imm = '0;
        exp_use_imm = 1'b0;
        exp_t1 = TAG_NONE;
        exp_t2 = TAG_NONE;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            mismatches = mismatches + 1;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    always @(posedge CLK) begin
        if (!nRST) begin
            m_busy = '0;
            for (int i = 0; i < `DISP_NREGS; i++) begin
                m_tag[i] = TAG_NONE;
            end
            clear_expected();
        end else begin
            // outputs still show the previous edge here
            compare_value("issue_valid", 32'(issue_valid), 32'(exp_valid));
            compare_value("issue_fu", 32'(issue_fu), 32'(exp_fu));
            compare_value("issue_op", 32'(issue_op), 32'(exp_op));
            compare_value("issue_rd", 32'(issue_rd), 32'(exp_rd));
            compare_value("issue_rs1", 32'(issue_rs1), 32'(exp_rs1));
            compare_value("issue_rs2", 32'(issue_rs2), 32'(exp_rs2));
            compare_value("issue_imm", issue_imm, exp_imm);
            compare_value("issue_use_imm", 32'(issue_use_imm), 32'(exp_use_imm));
            compare_value("issue_t1", 32'(issue_t1), 32'(exp_t1));
            compare_value("issue_t2", 32'(issue_t2), 32'(exp_t2));
            ref_decode(instr, d_fu, d_op, d_rd, d_rs1, d_rs2, d_imm, d_ui, d_wr, d_tag);
            // bit 0 stands for FU_NONE and is never busy
            busy_ext = {fu_busy, 1'b0};
            hz = busy_ext[d_fu] || (d_wr && m_busy[d_rd]);
            compare_value("freeze", 32'(freeze), 32'(instr_valid && hz && !branch_miss));
            disp = instr_valid && (d_fu != FU_NONE) && !hz && !branch_miss;
            clear_expected();
            if (disp) begin
                exp_valid = 1'b1;
                exp_fu = d_fu;
                exp_op = d_op;
                exp_rd = d_rd;
                exp_rs1 = d_rs1;
                exp_rs2 = d_rs2;
                exp_imm = d_imm;
                exp_use_imm = d_ui;
                exp_t1 = (wb_en && wb_reg == d_rs1) ? TAG_NONE : m_tag[d_rs1];
                exp_t2 = (wb_en && wb_reg == d_rs2) ? TAG_NONE : m_tag[d_rs2];
            end
            if (wb_en) begin
                m_busy[wb_reg] = 1'b0;
                m_tag[wb_reg] = TAG_NONE;
            end
            // dispatch wins over a writeback to the same register
            if (disp && d_wr) begin
                m_busy[d_rd] = 1'b1;
                m_tag[d_rd] = d_tag;
            end
        end
    end

    task automatic drive_inputs(input logic valid, input logic [31:0] w,
                                input logic [`DISP_NUM_FU-1:0] busy, input logic wbe,
                                input logic [`DISP_REG_W-1:0] wbr, input logic bm);
        @(negedge CLK);
        instr_valid = valid;
        instr = w;
        fu_busy = busy;
        wb_en = wbe;
        wb_reg = wbr;
        branch_miss = bm;
    endtask

    // present a word and hold it until freeze drops
    task automatic send_word(input logic [31:0] w, input logic [`DISP_NUM_FU-1:0] busy);
        int n;
        drive_inputs(1'b1, w, busy, 1'b0, 5'd0, 1'b0);
        #1;
        n = 0;
        while (freeze && n < 20) begin
            @(negedge CLK);
            #1;
            n++;
        end
        if (freeze) begin
            timeouts = timeouts + 1;
            $display("timeout: word %h still frozen after 20 cycles", w);
        end
    endtask

    initial begin
        int          n;
        logic [31:0] w;
        instr_valid = 1'b0;
        instr = '0;
        fu_busy = '0;
        wb_en = 1'b0;
        wb_reg = '0;
        branch_miss = 1'b0;
        n = 0;
        while (!nRST && n < 50) begin
            @(negedge CLK);
            n++;
        end
        if (!nRST) begin
            timeouts = timeouts + 1;
            $display("timeout: reset never released");
        end

        // random legal words, rd written back right after issue
        for (int i = 0; i < 60; i++) begin
            w = rand_word();
            send_word(w, 3'b000);
            drive_inputs(1'b0, 32'd0, 3'b000, 1'b1, w[11:7], 1'b0);
        end
        send_word(encode_word(7'd0, 5'd1, 5'd2, 3'b011, 5'd3, OPC_OP), 3'b000);
        send_word(encode_word(7'd5, 5'd1, 5'd2, 3'b011, 5'd3, OPC_OPIMM), 3'b000);
        send_word(encode_word(7'd0, 5'd1, 5'd2, 3'b010, 5'd0, OPC_BRANCH), 3'b000);
        send_word(32'hffff_ffff, 3'b000);

        // producer tags for x5 alu, x6 load, x7 jal
        send_word(encode_word(7'd0, 5'd2, 5'd1, 3'b000, 5'd5, OPC_OP), 3'b000);
        send_word(encode_word(7'd0, 5'd4, 5'd3, 3'b010, 5'd6, OPC_LOAD), 3'b000);
        send_word(encode_word(7'h12, 5'd3, 5'd9, 3'b101, 5'd7, OPC_JAL), 3'b000);
        send_word(encode_word(7'h20, 5'd6, 5'd5, 3'b000, 5'd8, OPC_OP), 3'b000);
        send_word(encode_word(7'h7f, 5'd5, 5'd7, 3'b010, 5'd1, OPC_STORE), 3'b000);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b1, 5'd5, 1'b0);
        send_word(encode_word(7'd0, 5'd6, 5'd5, 3'b000, 5'd4, OPC_BRANCH), 3'b000);
        // x6 written back in the same cycle as the read
        drive_inputs(1'b1, encode_word(7'h40, 5'd7, 5'd6, 3'b001, 5'd0, OPC_BRANCH),
                     3'b000, 1'b1, 5'd6, 1'b0);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b1, 5'd7, 1'b0);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b1, 5'd8, 1'b0);

        // write after write on x9
        send_word(encode_word(7'd0, 5'd5, 5'd0, 3'b000, 5'd9, OPC_OPIMM), 3'b000);
        w = encode_word(7'd0, 5'd3, 5'd9, 3'b110, 5'd9, OPC_OP);
        drive_inputs(1'b1, w, 3'b000, 1'b0, 5'd0, 1'b0);
        drive_inputs(1'b1, w, 3'b000, 1'b0, 5'd0, 1'b0);
        drive_inputs(1'b1, w, 3'b000, 1'b1, 5'd9, 1'b0);
        send_word(w, 3'b000);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b1, 5'd9, 1'b0);

        // busy units, own bit stalls and the others do not
        w = encode_word(7'd0, 5'd8, 5'd2, 3'b010, 5'd10, OPC_LOAD);
        drive_inputs(1'b1, w, 3'b010, 1'b0, 5'd0, 1'b0);
        send_word(w, 3'b101);
        w = encode_word(7'd0, 5'd3, 5'd2, 3'b100, 5'd11, OPC_OP);
        drive_inputs(1'b1, w, 3'b001, 1'b0, 5'd0, 1'b0);
        send_word(w, 3'b110);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b1, 5'd10, 1'b0);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b1, 5'd11, 1'b0);

        // flush, x12 must stay free afterwards
        w = encode_word(7'd0, 5'd1, 5'd2, 3'b000, 5'd12, OPC_OP);
        drive_inputs(1'b1, w, 3'b000, 1'b0, 5'd0, 1'b1);
        drive_inputs(1'b1, w, 3'b001, 1'b0, 5'd0, 1'b1);
        send_word(w, 3'b000);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b1, 5'd12, 1'b0);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b0, 5'd0, 1'b0);
        drive_inputs(1'b0, 32'd0, 3'b000, 1'b0, 5'd0, 1'b0);

        $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/dispatch_pkg.sv
source/instr_decoder.sv
source/reg_status_table.sv
source/dispatch_stage.sv
source/dispatch_top.sv
bench/clock_gen.sv
bench/dispatch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f vlog.f \
    --top-module dispatch_tb -o dispatch_sim
./obj_dir/dispatch_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    exit 0
else
    exit 1
fi
